// File: hdl/cpuPkg.sv
// CPU shared types and microcode fields
package cpuPkg;

    typedef logic [15:0] word_t;
    typedef logic [15:0] uinstr_t;
    typedef logic [2:0]  srcSel_t;
    typedef logic [2:0]  dstSel_t;

    typedef struct packed {
        logic ex;
        logic nx;
        logic ey;
        logic ny;
        logic f;
        logic no;
    } aluCtl_t;

    typedef struct packed {
        logic carry;
        logic zero;
        logic neg;
    } flags_t;

    typedef struct packed {
        logic jc;
        logic jz;
        logic jgt;
        logic jlt;
    } jmpMask_t;

    typedef struct packed {
        logic     eo;
        srcSel_t  busSrc;
        aluCtl_t  aluCtl;
        logic     rt;
        logic     pp;
        dstSel_t  dstSel;
        jmpMask_t jmpMask;
    } ctrl_t;

    // Bus source codes
    // Code 7 drives zero
    localparam srcSel_t srcPc  = 3'd0;
    localparam srcSel_t srcIoh = 3'd1;
    localparam srcSel_t srcIol = 3'd2;
    localparam srcSel_t srcRam = 3'd3;
    localparam srcSel_t srcX   = 3'd4;
    localparam srcSel_t srcY   = 3'd5;
    localparam srcSel_t srcD   = 3'd6;

    // Destination codes
    // Code 7 loads nothing
    localparam dstSel_t dstNone = 3'd0;
    localparam dstSel_t dstMar  = 3'd1;
    localparam dstSel_t dstIr   = 3'd2;
    localparam dstSel_t dstRam  = 3'd3;
    localparam dstSel_t dstX    = 3'd4;
    localparam dstSel_t dstY    = 3'd5;
    localparam dstSel_t dstD    = 3'd6;

    // Microinstruction bit positions
    localparam int eoBit  = 15;
    localparam int srcHi  = 14;
    localparam int srcLo  = 12;
    localparam int rtBit  = 11;
    localparam int ppBit  = 10;
    localparam int aluHi  = 14;
    localparam int aluLo  = 9;
    localparam int dstHi  = 8;
    localparam int dstLo  = 6;
    localparam int jmpHi  = 5;
    localparam int jmpLo  = 2;

endpackage

// File: hdl/uDecode.sv
// Microinstruction decoder
`timescale 1ns/1ps

module uDecode (
    input  cpuPkg::uinstr_t uinstr,
    output cpuPkg::ctrl_t   ctrl
);
    import cpuPkg::*;

    logic     eo;
    srcSel_t  srcField;
    aluCtl_t  aluField;
    dstSel_t  dstField;
    jmpMask_t jmpField;
    logic     rtField;
    logic     ppField;

    // Raw field extraction
    assign eo       = uinstr[eoBit];
    assign srcField = uinstr[srcHi:srcLo];
    assign aluField = uinstr[aluHi:aluLo];
    assign rtField  = uinstr[rtBit];
    assign ppField  = uinstr[ppBit];
    assign dstField = uinstr[dstHi:dstLo];
    assign jmpField = uinstr[jmpHi:jmpLo];

    // Bits 14..10 are shared between the source/RT/PP view and the ALU view
    always_comb begin
        ctrl.eo      = eo;
        ctrl.aluCtl  = aluField;
        ctrl.dstSel  = dstField;
        ctrl.jmpMask = jmpField;
        if (eo) begin
            ctrl.busSrc = srcPc;
            ctrl.rt     = 1'b0;
            ctrl.pp     = 1'b0;
        end else begin
            ctrl.busSrc = srcField;
            ctrl.rt     = rtField;
            ctrl.pp     = ppField;
        end
    end

endmodule

// File: hdl/alu.sv
// Six control bit ALU
`timescale 1ns/1ps

module alu (
    input  cpuPkg::ctrl_t  ctrl,
    input  cpuPkg::word_t  x,
    input  cpuPkg::word_t  y,
    output cpuPkg::word_t  aluOut,
    output cpuPkg::flags_t aluFlags
);
    import cpuPkg::*;

    word_t xOp;
    word_t yOp;
    word_t sum;
    word_t andRes;
    logic  carryOut;

    // Enable first, then invert, so ex=0 nx=1 yields all ones
    always_comb begin
        xOp = ctrl.aluCtl.ex ? x : '0;
        if (ctrl.aluCtl.nx) begin
            xOp = ~xOp;
        end
        yOp = ctrl.aluCtl.ey ? y : '0;
        if (ctrl.aluCtl.ny) begin
            yOp = ~yOp;
        end
    end

    assign {carryOut, sum} = {1'b0, xOp} + {1'b0, yOp};
    assign andRes = xOp & yOp;

    always_comb begin
        aluOut = ctrl.aluCtl.f ? sum : andRes;
        if (ctrl.aluCtl.no) begin
            aluOut = ~aluOut;
        end
    end

    // Carry only meaningful for the adder
    assign aluFlags.carry = ctrl.aluCtl.f & carryOut;
    assign aluFlags.zero  = (aluOut == '0);
    assign aluFlags.neg   = aluOut[15];

endmodule

// File: hdl/busRegs.sv
// Register block and bus select
`timescale 1ns/1ps

module busRegs #(
    parameter int ramAddrBits = 8
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  cpuPkg::ctrl_t          ctrl,
    input  logic [7:0]             ioIn,
    input  cpuPkg::word_t          aluOut,
    input  cpuPkg::flags_t         aluFlags,
    input  cpuPkg::word_t          ramData,
    output cpuPkg::word_t          bus,
    output cpuPkg::word_t          x,
    output cpuPkg::word_t          y,
    output cpuPkg::word_t          pc,
    output cpuPkg::word_t          instr,
    output logic [ramAddrBits-1:0] ramAddr,
    output logic                   ramWe
);
    import cpuPkg::*;

    word_t  dReg;
    flags_t flags;
    logic   jump;

    // Single bus driver per cycle
    always_comb begin
        if (ctrl.eo) begin
            bus = aluOut;
        end else begin
            case (ctrl.busSrc)
                srcPc:   bus = pc;
                srcIoh:  bus = {ioIn, 8'h00};
                srcIol:  bus = {8'h00, ioIn};
                srcRam:  bus = ramData;
                srcX:    bus = x;
                srcY:    bus = y;
                srcD:    bus = dReg;
                default: bus = '0;
            endcase
        end
    end

    assign ramWe = (ctrl.dstSel == dstRam);

    // Conditions test the flags from the last ALU cycle
    assign jump = (ctrl.jmpMask.jc  & flags.carry) |
                  (ctrl.jmpMask.jz  & flags.zero) |
                  (ctrl.jmpMask.jgt & ~flags.zero & ~flags.neg) |
                  (ctrl.jmpMask.jlt & flags.neg);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            x       <= '0;
            y       <= '0;
            dReg    <= '0;
            instr   <= '0;
            ramAddr <= '0;
        end else begin
            case (ctrl.dstSel)
                dstMar:  ramAddr <= bus[ramAddrBits-1:0];
                dstIr:   instr   <= bus;
                dstX:    x       <= bus;
                dstY:    y       <= bus;
                dstD:    dReg    <= bus;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            flags <= '0;
        end else if (ctrl.eo) begin
            flags <= aluFlags;
        end
    end

    // Jump wins over increment
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (jump) begin
            pc <= bus;
        end else if (ctrl.pp && !ctrl.eo) begin
            pc <= pc + 16'd1;
        end
    end

endmodule

// File: hdl/ram.sv
// Word RAM
`timescale 1ns/1ps

module ram #(
    parameter int ramAddrBits = 8
) (
    input  logic                   clk,
    input  logic [ramAddrBits-1:0] addr,
    input  logic                   we,
    input  cpuPkg::word_t          wrData,
    output cpuPkg::word_t          rdData
);
    import cpuPkg::*;

    localparam int depth = 1 << ramAddrBits;

    word_t mem [depth];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wrData;
        end
    end

    // Asynchronous read
    assign rdData = mem[addr];

endmodule

// File: hdl/cpuCore.sv
// Microcoded CPU datapath
`timescale 1ns/1ps

module cpuCore #(
    parameter int ramAddrBits = 8
) (
    input  logic            clk,
    input  logic            rstN,
    input  cpuPkg::uinstr_t uinstr,
    input  logic [7:0]      ioIn,
    output cpuPkg::word_t   busOut,
    output cpuPkg::word_t   pc,
    output cpuPkg::word_t   instr,
    output logic            instrEnd
);
    import cpuPkg::*;

    ctrl_t                  ctrl;
    word_t                  aluOut;
    flags_t                 aluFlags;
    word_t                  bus;
    word_t                  x;
    word_t                  y;
    word_t                  ramData;
    logic [ramAddrBits-1:0] ramAddr;
    logic                   ramWe;

    uDecode uDecodeInst (
        .uinstr (uinstr),
        .ctrl   (ctrl)
    );

    alu aluInst (
        .ctrl     (ctrl),
        .x        (x),
        .y        (y),
        .aluOut   (aluOut),
        .aluFlags (aluFlags)
    );

    busRegs #(
        .ramAddrBits (ramAddrBits)
    ) busRegsInst (
        .clk      (clk),
        .rstN     (rstN),
        .ctrl     (ctrl),
        .ioIn     (ioIn),
        .aluOut   (aluOut),
        .aluFlags (aluFlags),
        .ramData  (ramData),
        .bus      (bus),
        .x        (x),
        .y        (y),
        .pc       (pc),
        .instr    (instr),
        .ramAddr  (ramAddr),
        .ramWe    (ramWe)
    );

    ram #(
        .ramAddrBits (ramAddrBits)
    ) ramInst (
        .clk    (clk),
        .addr   (ramAddr),
        .we     (ramWe),
        .wrData (bus),
        .rdData (ramData)
    );

    assign busOut   = bus;
    assign instrEnd = ctrl.rt;

endmodule

// File: verification/cpuCoreTb_assert.sv
// Datapath assertions
`timescale 1ns/1ps

module cpuCoreTb_assert (
    input logic          clk,
    input logic          rstN,
    input cpuPkg::ctrl_t ctrl,
    input cpuPkg::word_t bus,
    input cpuPkg::word_t x,
    input cpuPkg::word_t pc,
    input logic          jump
);
    import cpuPkg::*;

    int failCount = 0;

    busCarriesX: assert property (@(posedge clk) disable iff (!rstN)
        (!ctrl.eo && ctrl.busSrc == srcX) |-> (bus == x))
        else begin
            $error("Bus differs from X while X is the selected source");
            failCount++;
        end

    // Plain increment when no jump is taken
    ppIncrements: assert property (@(posedge clk) disable iff (!rstN)
        (ctrl.pp && !ctrl.eo && !jump) |=> (pc == $past(pc) + 16'd1))
        else begin
            $error("Program counter did not advance by one after PP");
            failCount++;
        end

    rtMaskedByEo: assert property (@(posedge clk) disable iff (!rstN)
        ctrl.eo |-> !ctrl.rt)
        else begin
            $error("RT decoded while the ALU drives the bus");
            failCount++;
        end

endmodule

// File: verification/cpuCoreTb.sv
// CPU datapath testbench
`timescale 1ns/1ps

module cpuCoreTb;
    import cpuPkg::*;

    localparam int clkPeriod   = 8;
    localparam int resetCycles = 16;
    localparam int ramBits     = 8;
    localparam logic [3:0] jmpC  = 4'b1000;
    localparam logic [3:0] jmpZ  = 4'b0100;
    localparam logic [3:0] jmpGt = 4'b0010;
    localparam logic [3:0] jmpLt = 4'b0001;

    typedef struct packed {
        logic [15:0] uinstr;
        logic [7:0]  ioIn;
        logic [15:0] expBus;
        logic [15:0] expPc;
        logic [15:0] expInstr;
        logic        expRt;
    } step_t;

    logic        clk;
    logic        rstN;
    logic [15:0] uinstr;
    logic [7:0]  ioIn;
    logic [15:0] busOut;
    logic [15:0] pc;
    logic [15:0] instr;
    logic        instrEnd;
    logic        tableReady = 1'b0;
    int          errCount = 0;
    int          badTests = 0;
    int          assertFails = 0;

    step_t       steps [$];
    string       names [$];

    // Reference state advanced in table order
    logic [15:0]        mX = '0;
    logic [15:0]        mY = '0;
    logic [15:0]        mD = '0;
    logic [15:0]        mPc = '0;
    logic [15:0]        mInstr = '0;
    logic [ramBits-1:0] mMar = '0;
    logic               mCarry = 1'b0;
    logic               mZero = 1'b0;
    logic               mNeg = 1'b0;
    logic [15:0]        mRam [1 << ramBits];

    cpuCore #(.ramAddrBits(ramBits)) UUT (
        .clk      (clk),
        .rstN     (rstN),
        .uinstr   (uinstr),
        .ioIn     (ioIn),
        .busOut   (busOut),
        .pc       (pc),
        .instr    (instr),
        .instrEnd (instrEnd)
    );

    bind busRegs cpuCoreTb_assert busRegsChecks (
        .clk  (clk),
        .rstN (rstN),
        .ctrl (ctrl),
        .bus  (bus),
        .x    (x),
        .pc   (pc),
        .jump (jump)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic logic [7:0] rnd8();
        logic [31:0] r;
        r = $urandom;
        return r[7:0];
    endfunction

    function automatic logic [15:0] mkMove(input logic [2:0] src, input logic [2:0] dst,
                                           input logic rt, input logic pp,
                                           input logic [3:0] jm);
        return {1'b0, src, rt, pp, 1'b0, dst, jm, 2'b00};
    endfunction

    function automatic logic [15:0] mkAlu(input logic [5:0] ctl, input logic [2:0] dst,
                                          input logic [3:0] jm);
        return {1'b1, ctl, dst, jm, 2'b00};
    endfunction

    // Carry out lands in bit 16
    // ctl bits are ex nx ey ny f no
    function automatic logic [16:0] refAlu(input logic [5:0] ctl, input logic [15:0] a,
                                           input logic [15:0] b);
        logic [15:0] xa;
        logic [15:0] yb;
        logic [16:0] res;
        xa = ctl[5] ? a : 16'h0000;
        yb = ctl[3] ? b : 16'h0000;
        if (ctl[4]) xa = ~xa;
        if (ctl[2]) yb = ~yb;
        res = ctl[1] ? ({1'b0, xa} + {1'b0, yb}) : {1'b0, xa & yb};
        if (ctl[0]) res[15:0] = ~res[15:0];
        return res;
    endfunction

    task automatic addStep(input string name, input logic [15:0] ui, input logic [7:0] io);
        logic        eo;
        logic [16:0] aluRes;
        logic [15:0] bus;
        logic        jump;
        step_t       s;
        eo = ui[15];
        aluRes = refAlu(ui[14:9], mX, mY);
        if (eo) begin
            bus = aluRes[15:0];
        end else begin
            case (ui[14:12])
                srcPc:   bus = mPc;
                srcIoh:  bus = {io, 8'h00};
                srcIol:  bus = {8'h00, io};
                srcRam:  bus = mRam[mMar];
                srcX:    bus = mX;
                srcY:    bus = mY;
                srcD:    bus = mD;
                default: bus = 16'h0000;
            endcase
        end
        jump = (ui[5] & mCarry) | (ui[4] & mZero) | (ui[3] & ~mZero & ~mNeg) | (ui[2] & mNeg);
        case (ui[8:6])
            dstMar:  mMar = bus[ramBits-1:0];
            dstIr:   mInstr = bus;
            dstRam:  mRam[mMar] = bus;
            dstX:    mX = bus;
            dstY:    mY = bus;
            dstD:    mD = bus;
            default: ;
        endcase
        if (eo) begin
            mCarry = aluRes[16];
            mZero = (aluRes[15:0] == 16'h0000);
            mNeg = aluRes[15];
        end
        if (jump) mPc = bus;
        else if (ui[10] && !eo) mPc = mPc + 16'd1;
        s = '{ui, io, bus, mPc, mInstr, ui[11] & ~eo};
        steps.push_back(s);
        names.push_back(name);
    endtask

    // Full 16-bit random X and Y built from byte inputs
    task automatic loadRandomXY();
        addStep("ldXHi", mkMove(srcIoh, dstX, 1'b0, 1'b0, 4'h0), rnd8());
        addStep("ldYLo", mkMove(srcIol, dstY, 1'b0, 1'b0, 4'h0), rnd8());
        addStep("joinToD", mkAlu(6'b101010, dstD, 4'h0), 8'h00);
        addStep("ldXHi", mkMove(srcIoh, dstX, 1'b0, 1'b0, 4'h0), rnd8());
        addStep("ldYLo", mkMove(srcIol, dstY, 1'b0, 1'b0, 4'h0), rnd8());
        addStep("joinToY", mkAlu(6'b101010, dstY, 4'h0), 8'h00);
        addStep("dToX", mkMove(srcD, dstX, 1'b0, 1'b0, 4'h0), 8'h00);
    endtask

    task automatic buildTable();
        logic [5:0] ops [8];
        string      opNames [8];
        logic [7:0] addrA;
        ops = '{6'b101010, 6'b101000, 6'b100111, 6'b000000,
                6'b010111, 6'b111011, 6'b111101, 6'b011111};
        opNames = '{"aluAdd", "aluAnd", "aluNegX", "aluZero",
                    "aluOne", "aluSub", "aluOr", "aluFiveSet"};
        addStep("resetPcOut", mkMove(srcPc, dstNone, 1'b0, 1'b0, 4'h0), 8'h00);
        addStep("zeroUinstr", 16'h0000, 8'h00);
        addStep("iolToX", mkMove(srcIol, dstX, 1'b0, 1'b0, 4'h0), rnd8());
        addStep("iohToY", mkMove(srcIoh, dstY, 1'b0, 1'b0, 4'h0), rnd8());
        addStep("iolToD", mkMove(srcIol, dstD, 1'b0, 1'b0, 4'h0), rnd8());
        addStep("xOut", mkMove(srcX, dstNone, 1'b0, 1'b0, 4'h0), 8'h00);
        addStep("yOut", mkMove(srcY, dstNone, 1'b0, 1'b0, 4'h0), 8'h00);
        addStep("dOut", mkMove(srcD, dstNone, 1'b0, 1'b0, 4'h0), 8'h00);
        addStep("iohToIr", mkMove(srcIoh, dstIr, 1'b0, 1'b0, 4'h0), rnd8());
        for (int r = 0; r < 2; r++) begin
            loadRandomXY();
            for (int k = 0; k < 8; k++) begin
                addStep(opNames[k], mkAlu(ops[k], dstNone, 4'h0), 8'h00);
            end
        end
        addrA = rnd8();
        addStep("ldAddrX", mkMove(srcIol, dstX, 1'b0, 1'b0, 4'h0), addrA);
        addStep("marFromX", mkMove(srcX, dstMar, 1'b0, 1'b0, 4'h0), 8'h00);
        addStep("ramFromY", mkMove(srcY, dstRam, 1'b0, 1'b0, 4'h0), 8'h00);
        addStep("ramOut", mkMove(srcRam, dstNone, 1'b0, 1'b0, 4'h0), 8'h00);
        addStep("ldAddrD", mkMove(srcIol, dstD, 1'b0, 1'b0, 4'h0), addrA ^ 8'h5a);
        addStep("marFromD", mkMove(srcD, dstMar, 1'b0, 1'b0, 4'h0), 8'h00);
        addStep("ramFromX", mkMove(srcX, dstRam, 1'b0, 1'b0, 4'h0), 8'h00);
        addStep("marBack", mkMove(srcX, dstMar, 1'b0, 1'b0, 4'h0), 8'h00);
        addStep("ramKept", mkMove(srcRam, dstNone, 1'b0, 1'b0, 4'h0), 8'h00);
        addStep("ppIncr1", mkMove(srcPc, dstNone, 1'b0, 1'b1, 4'h0), 8'h00);
        addStep("ppIncr2", mkMove(srcPc, dstNone, 1'b0, 1'b1, 4'h0), 8'h00);
        addStep("aluZeroFlag", mkAlu(6'b000000, dstNone, 4'h0), 8'h00);
        addStep("jzTaken", mkMove(srcY, dstNone, 1'b0, 1'b0, jmpZ), 8'h00);
        addStep("aluPositive", mkAlu(6'b010111, dstNone, 4'h0), 8'h00);
        addStep("jltNotTaken", mkMove(srcY, dstNone, 1'b0, 1'b1, jmpLt), 8'h00);
        addStep("jgtTaken", mkMove(srcD, dstNone, 1'b0, 1'b0, jmpGt), 8'h00);
        addStep("aluCarry", mkAlu(6'b010110, dstNone, 4'h0), 8'h00);
        addStep("jcTaken", mkMove(srcX, dstNone, 1'b0, 1'b0, jmpC), 8'h00);
        addStep("jltTaken", mkMove(srcD, dstNone, 1'b0, 1'b0, jmpLt), 8'h00);
        addStep("aluNoCarry", mkAlu(6'b101000, dstNone, 4'h0), 8'h00);
        addStep("jcNotTaken", mkMove(srcY, dstNone, 1'b0, 1'b1, jmpC), 8'h00);
        addStep("rtEnd", mkMove(srcPc, dstNone, 1'b1, 1'b1, 4'h0), 8'h00);
        addStep("rtMaskedByEo", mkAlu(6'b100111, dstNone, 4'h0), 8'h00);
    endtask

    task automatic checkVal(input string name, input string what,
                            input logic [15:0] expVal, input logic [15:0] actVal);
        assert (actVal === expVal) else begin
            $display("[FAIL] %s %s expected %h actual %h", name, what, expVal, actVal);
            errCount++;
        end
    endtask

    // Drive one entry and follow it with an idle cycle
    task automatic runStep(input int i);
        step_t s;
        int    errsBefore;
        s = steps[i];
        errsBefore = errCount;
        @(posedge clk);
        uinstr <= s.uinstr;
        ioIn   <= s.ioIn;
        @(negedge clk);
        checkVal(names[i], "busOut", s.expBus, busOut);
        checkVal(names[i], "instrEnd", {15'd0, s.expRt}, {15'd0, instrEnd});
        @(posedge clk);
        uinstr <= 16'h0000;
        @(negedge clk);
        checkVal(names[i], "pc", s.expPc, pc);
        checkVal(names[i], "instr", s.expInstr, instr);
        if (errCount == errsBefore) begin
            $display("test %0d %s: ok", i, names[i]);
        end else begin
            $display("test %0d %s: %0d mismatches", i, names[i], errCount - errsBefore);
            badTests++;
        end
    endtask

    initial begin
        rstN   = 1'b0;
        uinstr = 16'h0000;
        ioIn   = 8'h00;
        void'($urandom(32'he169_cd75));
        buildTable();
        tableReady = 1'b1;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
        for (int i = 0; i < steps.size(); i++) begin
            runStep(i);
        end
        assertFails = UUT.busRegsInst.busRegsChecks.failCount;
        $display("Summary: %0d run, %0d passed, %0d failed, %0d mismatches, %0d assertion errors",
                 steps.size(), steps.size() - badTests, badTests, errCount, assertFails);
        if (errCount == 0 && assertFails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        int limitNs;
        wait (tableReady);
        limitNs = (steps.size() * 2 + resetCycles + 20) * clkPeriod;
        #(limitNs);
        $display("Timeout: the run did not finish within %0d ns", limitNs);
        $display("tests failed");
        $finish;
    end

endmodule

// File: cpuCore.f
hdl/cpuPkg.sv
hdl/uDecode.sv
hdl/alu.sv
hdl/busRegs.sv
hdl/ram.sv
hdl/cpuCore.sv
verification/cpuCoreTb_assert.sv
verification/cpuCoreTb.sv

// File: Makefile
SIM       := verilator
TOP       := cpuCoreTb
FILELIST  := cpuCore.f
SIMFLAGS  := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "tests failed" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "all tests passed" $(LOG); then echo "Simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
